// ==== src/plps_pkg.sv ====
`default_nettype none

package plps_pkg;

	// sample format, 4 lanes of signed 16 bit per clock
	localparam int LANES = 4;
	localparam int SAMPLE_W = 16;
	localparam int PAIR_W = 2 * SAMPLE_W;

	// Q1.15 scaling used by the mixer products
	localparam int FRAC_W = SAMPLE_W - 1;

	// qubit drive 0, qubit drive 1, readout drive
	localparam int N_GEN = 3;

	// table and capture depths
	localparam int FREQ_AW = 4;
	localparam int ENV_AW = 6;
	localparam int CAP_AW = 6;

	// 0..2 carrier tables, 3..5 envelope tables
	localparam int TBL_SEL_W = 3;

	// adc, dac and generator words
	typedef logic [LANES*SAMPLE_W-1:0] sample_word_t;

	// lane i: cos or x in the low half, sin or y in the high half
	typedef logic [LANES*PAIR_W-1:0] table_word_t;

endpackage

`default_nettype wire

// ==== src/wave_mem.sv ====
`default_nettype none

module wave_mem #(
	parameter int TABLE_ID = 0,
	parameter int AW = plps_pkg::ENV_AW,
	parameter type word_t = plps_pkg::table_word_t
) (
	input logic dspif,
	input logic rst_n,
	input logic tbl_we,
	input logic [plps_pkg::TBL_SEL_W-1:0] tbl_sel,
	input logic [plps_pkg::ENV_AW-1:0] tbl_addr,
	input word_t tbl_wdata,
	input logic [AW-1:0] rd_addr,
	output word_t rd_data
);

	word_t mem [2**AW];
	logic wr_hit;

	// only the addressed table takes the write
	assign wr_hit = tbl_we && (tbl_sel == plps_pkg::TBL_SEL_W'(TABLE_ID));

	always_ff @(posedge dspif) begin
		if (wr_hit) begin
			mem[tbl_addr[AW-1:0]] <= tbl_wdata;
		end
	end

	// one registered read per clock
	always_ff @(posedge dspif or negedge rst_n) begin
		if (!rst_n) begin
			rd_data <= '0;
		end else begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

`default_nettype wire

// ==== src/env_sequencer.sv ====
`default_nettype none

module env_sequencer (
	input logic dspif,
	input logic rst_n,
	input logic run,
	input logic [plps_pkg::FREQ_AW-1:0] freq_sel0,
	input logic [plps_pkg::FREQ_AW-1:0] freq_sel1,
	input logic [plps_pkg::FREQ_AW-1:0] freq_sel2,
	output logic [plps_pkg::ENV_AW-1:0] env_addr,
	output logic [plps_pkg::FREQ_AW-1:0] freq_addr0,
	output logic [plps_pkg::FREQ_AW-1:0] freq_addr1,
	output logic [plps_pkg::FREQ_AW-1:0] freq_addr2
);

	// envelope address, wraps at the table end
	always_ff @(posedge dspif or negedge rst_n) begin
		if (!rst_n) begin
			env_addr <= '0;
		end else if (run) begin
			env_addr <= env_addr + 1'b1;
		end
	end

	// carrier selects, one register stage
	always_ff @(posedge dspif or negedge rst_n) begin
		if (!rst_n) begin
			freq_addr0 <= '0;
			freq_addr1 <= '0;
			freq_addr2 <= '0;
		end else begin
			freq_addr0 <= freq_sel0;
			freq_addr1 <= freq_sel1;
			freq_addr2 <= freq_sel2;
		end
	end

endmodule

`default_nettype wire

// ==== src/ammod.sv ====
`default_nettype none

module ammod (
	input logic dspif,
	input logic rst_n,
	input plps_pkg::table_word_t carrier,
	input plps_pkg::table_word_t envelope,
	input logic signed [plps_pkg::SAMPLE_W-1:0] amp,
	output plps_pkg::sample_word_t mix
);

	for (genvar i = 0; i < plps_pkg::LANES; i++) begin : g_lane
		logic signed [plps_pkg::SAMPLE_W-1:0] c;
		logic signed [plps_pkg::SAMPLE_W-1:0] s;
		logic signed [plps_pkg::SAMPLE_W-1:0] x;
		logic signed [plps_pkg::SAMPLE_W-1:0] y;
		logic signed [2*plps_pkg::SAMPLE_W-1:0] xc_r;
		logic signed [2*plps_pkg::SAMPLE_W-1:0] ys_r;
		logic signed [2*plps_pkg::SAMPLE_W:0] diff;
		logic signed [plps_pkg::SAMPLE_W-1:0] re_r;
		logic signed [2*plps_pkg::SAMPLE_W-1:0] scaled;
		logic signed [plps_pkg::SAMPLE_W-1:0] mix_r;

		// unpack cos/sin and x/y for this lane
		assign c = carrier[i*plps_pkg::PAIR_W +: plps_pkg::SAMPLE_W];
		assign s = carrier[i*plps_pkg::PAIR_W + plps_pkg::SAMPLE_W +: plps_pkg::SAMPLE_W];
		assign x = envelope[i*plps_pkg::PAIR_W +: plps_pkg::SAMPLE_W];
		assign y = envelope[i*plps_pkg::PAIR_W + plps_pkg::SAMPLE_W +: plps_pkg::SAMPLE_W];

		// real part of the complex product
		assign diff = xc_r - ys_r;

		// amplitude scale in Q1.15
		assign scaled = re_r * amp;

		always_ff @(posedge dspif or negedge rst_n) begin
			if (!rst_n) begin
				xc_r <= '0;
				ys_r <= '0;
				re_r <= '0;
				mix_r <= '0;
			end else begin
				xc_r <= x * c;
				ys_r <= y * s;
				// >>> 15, keep 16 bits
				re_r <= diff[plps_pkg::FRAC_W +: plps_pkg::SAMPLE_W];
				mix_r <= scaled[plps_pkg::FRAC_W +: plps_pkg::SAMPLE_W];
			end
		end

		assign mix[i*plps_pkg::SAMPLE_W +: plps_pkg::SAMPLE_W] = mix_r;
	end

endmodule

`default_nettype wire

// ==== src/dac_mix.sv ====
`default_nettype none

module dac_mix (
	input logic dspif,
	input logic rst_n,
	input plps_pkg::sample_word_t gen0,
	input plps_pkg::sample_word_t gen1,
	input plps_pkg::sample_word_t gen2,
	output plps_pkg::sample_word_t dac0,
	output plps_pkg::sample_word_t dac1
);

	plps_pkg::sample_word_t sum_w;
	plps_pkg::sample_word_t sum_r;
	plps_pkg::sample_word_t gen0_r;

	// lane-wise add, overflow wraps
	always_comb begin
		for (int i = 0; i < plps_pkg::LANES; i++) begin
			sum_w[i*plps_pkg::SAMPLE_W +: plps_pkg::SAMPLE_W] =
				gen1[i*plps_pkg::SAMPLE_W +: plps_pkg::SAMPLE_W] +
				gen2[i*plps_pkg::SAMPLE_W +: plps_pkg::SAMPLE_W];
		end
	end

	// gen0 delayed to line up with the sum
	always_ff @(posedge dspif or negedge rst_n) begin
		if (!rst_n) begin
			gen0_r <= '0;
			sum_r <= '0;
		end else begin
			gen0_r <= gen0;
			sum_r <= sum_w;
		end
	end

	always_ff @(posedge dspif or negedge rst_n) begin
		if (!rst_n) begin
			dac0 <= '0;
			dac1 <= '0;
		end else begin
			dac0 <= gen0_r;
			dac1 <= sum_r;
		end
	end

endmodule

`default_nettype wire

// ==== src/capture_buf.sv ====
`default_nettype none

module capture_buf #(
	parameter type word_t = plps_pkg::sample_word_t,
	parameter int IN_REG = 0
) (
	input logic dspif,
	input logic rst_n,
	input logic clear,
	input word_t wdata,
	input logic [plps_pkg::CAP_AW-1:0] rd_addr,
	output word_t rd_data,
	output logic full
);

	word_t mem [2**plps_pkg::CAP_AW];
	word_t wdata_q;
	logic [plps_pkg::CAP_AW-1:0] wr_addr;

	// optional input delay line
	if (IN_REG > 0) begin : g_in_reg
		word_t pipe [IN_REG];

		always_ff @(posedge dspif) begin
			pipe[0] <= wdata;
			for (int k = 1; k < IN_REG; k++) begin
				pipe[k] <= pipe[k-1];
			end
		end

		assign wdata_q = pipe[IN_REG-1];
	end else begin : g_direct
		assign wdata_q = wdata;
	end

	// address sticks at the last entry, then full
	always_ff @(posedge dspif or negedge rst_n) begin
		if (!rst_n) begin
			wr_addr <= '0;
			full <= 1'b0;
		end else if (clear) begin
			wr_addr <= '0;
			full <= 1'b0;
		end else if (!full) begin
			if (&wr_addr) begin
				full <= 1'b1;
			end else begin
				wr_addr <= wr_addr + 1'b1;
			end
		end
	end

	always_ff @(posedge dspif) begin
		if (!full) begin
			mem[wr_addr] <= wdata_q;
		end
	end

	// readback, one cycle
	always_ff @(posedge dspif or negedge rst_n) begin
		if (!rst_n) begin
			rd_data <= '0;
		end else begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

`default_nettype wire

// ==== src/dsp_top.sv ====
`default_nettype none

module dsp_top (
	input logic dspif,
	input logic rst_n,
	input logic run,
	input logic signed [plps_pkg::SAMPLE_W-1:0] amp,
	input logic [plps_pkg::FREQ_AW-1:0] freq_sel0,
	input logic [plps_pkg::FREQ_AW-1:0] freq_sel1,
	input logic [plps_pkg::FREQ_AW-1:0] freq_sel2,
	input logic tbl_we,
	input logic [plps_pkg::TBL_SEL_W-1:0] tbl_sel,
	input logic [plps_pkg::ENV_AW-1:0] tbl_addr,
	input plps_pkg::table_word_t tbl_wdata,
	input plps_pkg::sample_word_t adc,
	input logic cap_clear,
	input logic [plps_pkg::CAP_AW-1:0] rd_addr,
	output plps_pkg::sample_word_t dac0,
	output plps_pkg::sample_word_t dac1,
	output plps_pkg::sample_word_t acq_rd_data,
	output plps_pkg::sample_word_t mon_rd_data,
	output logic acq_full,
	output logic mon_full
);

	logic [plps_pkg::ENV_AW-1:0] env_addr;
	logic [plps_pkg::FREQ_AW-1:0] freq_addr [plps_pkg::N_GEN];
	plps_pkg::table_word_t carrier [plps_pkg::N_GEN];
	plps_pkg::table_word_t envelope [plps_pkg::N_GEN];
	plps_pkg::sample_word_t gen [plps_pkg::N_GEN];

	env_sequencer env_sequencer_inst (
		.dspif(dspif),
		.rst_n(rst_n),
		.run(run),
		.freq_sel0(freq_sel0),
		.freq_sel1(freq_sel1),
		.freq_sel2(freq_sel2),
		.env_addr(env_addr),
		.freq_addr0(freq_addr[0]),
		.freq_addr1(freq_addr[1]),
		.freq_addr2(freq_addr[2])
	);

	// one carrier table, one envelope table and a mixer per generator
	for (genvar g = 0; g < plps_pkg::N_GEN; g++) begin : g_gen
		wave_mem #(
			.TABLE_ID(g),
			.AW(plps_pkg::FREQ_AW),
			.word_t(plps_pkg::table_word_t)
		) freq_mem_inst (
			.dspif(dspif),
			.rst_n(rst_n),
			.tbl_we(tbl_we),
			.tbl_sel(tbl_sel),
			.tbl_addr(tbl_addr),
			.tbl_wdata(tbl_wdata),
			.rd_addr(freq_addr[g]),
			.rd_data(carrier[g])
		);

		wave_mem #(
			.TABLE_ID(g + plps_pkg::N_GEN),
			.AW(plps_pkg::ENV_AW),
			.word_t(plps_pkg::table_word_t)
		) env_mem_inst (
			.dspif(dspif),
			.rst_n(rst_n),
			.tbl_we(tbl_we),
			.tbl_sel(tbl_sel),
			.tbl_addr(tbl_addr),
			.tbl_wdata(tbl_wdata),
			.rd_addr(env_addr),
			.rd_data(envelope[g])
		);

		ammod ammod_inst (
			.dspif(dspif),
			.rst_n(rst_n),
			.carrier(carrier[g]),
			.envelope(envelope[g]),
			.amp(amp),
			.mix(gen[g])
		);
	end

	dac_mix dac_mix_inst (
		.dspif(dspif),
		.rst_n(rst_n),
		.gen0(gen[0]),
		.gen1(gen[1]),
		.gen2(gen[2]),
		.dac0(dac0),
		.dac1(dac1)
	);

	// adc capture, with one input register
	capture_buf #(
		.word_t(plps_pkg::sample_word_t),
		.IN_REG(1)
	) acq_buf_inst (
		.dspif(dspif),
		.rst_n(rst_n),
		.clear(cap_clear),
		.wdata(adc),
		.rd_addr(rd_addr),
		.rd_data(acq_rd_data),
		.full(acq_full)
	);

	// dac1 monitor
	capture_buf #(
		.word_t(plps_pkg::sample_word_t),
		.IN_REG(0)
	) mon_buf_inst (
		.dspif(dspif),
		.rst_n(rst_n),
		.clear(cap_clear),
		.wdata(dac1),
		.rd_addr(rd_addr),
		.rd_data(mon_rd_data),
		.full(mon_full)
	);

endmodule

`default_nettype wire

// ==== verification/tb_clock.sv ====
`default_nettype none

module tb_clock #(
	parameter int PERIOD = 4
) (
	output logic dspif
);

	initial begin
		dspif = 1'b0;
		forever begin
			#(PERIOD / 2) dspif = ~dspif;
		end
	end

endmodule

`default_nettype wire

// ==== verification/dsp_checker.sv ====
`default_nettype none

module dsp_checker (
	input logic dspif,
	input logic rst_n,
	input logic cap_clear,
	input logic [plps_pkg::CAP_AW-1:0] rd_addr,
	input plps_pkg::sample_word_t dac0,
	input plps_pkg::sample_word_t dac1,
	input plps_pkg::sample_word_t acq_rd_data,
	input plps_pkg::sample_word_t mon_rd_data,
	input logic acq_full,
	input logic mon_full
);

	int fail_count = 0;

	// everything cleared when reset lets go
	reset_clear: assert property (@(posedge dspif) $rose(rst_n) |->
		(dac0 == '0 && dac1 == '0 && acq_rd_data == '0 && mon_rd_data == '0 &&
		!acq_full && !mon_full))
		else begin
			fail_count++;
			$error("outputs not zero after reset");
		end

	full_hold: assert property (@(posedge dspif) disable iff (!rst_n)
		!cap_clear && (acq_full || mon_full) |=> (acq_full || !$past(acq_full)) &&
		(mon_full || !$past(mon_full)))
		else begin
			fail_count++;
			$error("full flag dropped without a clear");
		end

	// locked buffer, so a held read address returns a held word
	acq_locked: assert property (@(posedge dspif) disable iff (!rst_n)
		acq_full && $past(acq_full) && $stable(rd_addr) |=> $stable(acq_rd_data))
		else begin
			fail_count++;
			$error("acquisition buffer written after it was full");
		end

	clear_drops_full: assert property (@(posedge dspif) disable iff (!rst_n)
		cap_clear |=> !acq_full && !mon_full)
		else begin
			fail_count++;
			$error("full flag still high one edge after cap_clear");
		end

endmodule

bind dsp_top dsp_checker dsp_checker_inst (
	.dspif(dspif),
	.rst_n(rst_n),
	.cap_clear(cap_clear),
	.rd_addr(rd_addr),
	.dac0(dac0),
	.dac1(dac1),
	.acq_rd_data(acq_rd_data),
	.mon_rd_data(mon_rd_data),
	.acq_full(acq_full),
	.mon_full(mon_full)
);

`default_nettype wire

// ==== verification/tb_dsp.sv ====
`default_nettype none

module tb_dsp;

	localparam int LOAD_CYCLES = 3 * (2**plps_pkg::FREQ_AW) + 3 * (2**plps_pkg::ENV_AW);
	localparam int MAX_CYCLES = 4 * (64 + 64 + 20) + LOAD_CYCLES;
	localparam int PIPE = 6;

	logic dspif;
	logic rst_n;
	logic run;
	logic signed [plps_pkg::SAMPLE_W-1:0] amp;
	logic [plps_pkg::FREQ_AW-1:0] freq_sel0;
	logic [plps_pkg::FREQ_AW-1:0] freq_sel1;
	logic [plps_pkg::FREQ_AW-1:0] freq_sel2;
	logic tbl_we;
	logic [plps_pkg::TBL_SEL_W-1:0] tbl_sel;
	logic [plps_pkg::ENV_AW-1:0] tbl_addr;
	plps_pkg::table_word_t tbl_wdata;
	plps_pkg::sample_word_t adc;
	logic cap_clear;
	logic [plps_pkg::CAP_AW-1:0] rd_addr;
	plps_pkg::sample_word_t dac0;
	plps_pkg::sample_word_t dac1;
	plps_pkg::sample_word_t acq_rd_data;
	plps_pkg::sample_word_t mon_rd_data;
	logic acq_full;
	logic mon_full;

	// shadow tables and logs of what crossed the DUT ports
	plps_pkg::table_word_t car_sh [plps_pkg::N_GEN][2**plps_pkg::FREQ_AW];
	plps_pkg::table_word_t env_sh [plps_pkg::N_GEN][2**plps_pkg::ENV_AW];
	plps_pkg::sample_word_t adc_log [MAX_CYCLES];
	plps_pkg::sample_word_t dac1_log [MAX_CYCLES];
	plps_pkg::sample_word_t exp0 [PIPE];
	plps_pkg::sample_word_t exp1 [PIPE];
	logic [PIPE-1:0] exp_vld;
	logic model_en;
	logic [plps_pkg::ENV_AW-1:0] m_addr;
	logic [plps_pkg::FREQ_AW-1:0] m_fsel [plps_pkg::N_GEN];
	logic [plps_pkg::CAP_AW-1:0] m_wcnt;
	logic m_full;
	logic rd_chk;
	logic rd_chk_q;
	plps_pkg::sample_word_t rd_acq;
	plps_pkg::sample_word_t rd_acq_q;
	plps_pkg::sample_word_t rd_mon;
	plps_pkg::sample_word_t rd_mon_q;
	int cyc = 0;
	int n_errors = 0;
	string phase = "reset";

	tb_clock #(.PERIOD(4)) tb_clock_inst (.dspif(dspif));

	dsp_top dsp_top_inst (.*);

	// real part of env * carrier, then amp, both in Q1.15
	function automatic plps_pkg::sample_word_t gen_model(input plps_pkg::table_word_t car,
			input plps_pkg::table_word_t env, input logic signed [15:0] a);
		plps_pkg::sample_word_t r;
		logic signed [15:0] c;
		logic signed [15:0] s;
		logic signed [15:0] x;
		logic signed [15:0] y;
		logic signed [15:0] re;
		longint p;
		for (int i = 0; i < plps_pkg::LANES; i++) begin
			c = car[i*plps_pkg::PAIR_W +: 16];
			s = car[i*plps_pkg::PAIR_W + 16 +: 16];
			x = env[i*plps_pkg::PAIR_W +: 16];
			y = env[i*plps_pkg::PAIR_W + 16 +: 16];
			p = (longint'(x) * longint'(c) - longint'(y) * longint'(s)) >>> plps_pkg::FRAC_W;
			re = p[15:0];
			p = (longint'(re) * longint'(a)) >>> plps_pkg::FRAC_W;
			r[i*plps_pkg::SAMPLE_W +: plps_pkg::SAMPLE_W] = p[15:0];
		end
		return r;
	endfunction

	function automatic plps_pkg::sample_word_t wrap_sum(input plps_pkg::sample_word_t a,
			input plps_pkg::sample_word_t b);
		plps_pkg::sample_word_t r;
		for (int i = 0; i < plps_pkg::LANES; i++) begin
			r[i*16 +: 16] = a[i*16 +: 16] + b[i*16 +: 16];
		end
		return r;
	endfunction

	task automatic show_mismatch(input string what, input plps_pkg::sample_word_t expected,
			input plps_pkg::sample_word_t actual);
		n_errors++;
		$display("CHECK FAILED %s/%s: expected %h actual %h", phase, what, expected, actual);
	endtask

	// expected DAC words, 6 cycles behind the address they come from
	always @(posedge dspif or negedge rst_n) begin
		if (!rst_n) begin
			m_addr <= '0;
			m_fsel <= '{default: '0};
			m_wcnt <= '0;
			m_full <= 1'b0;
			exp_vld <= '0;
			rd_chk_q <= 1'b0;
		end else begin
			if (run) begin
				m_addr <= m_addr + 1'b1;
			end
			m_fsel[0] <= freq_sel0;
			m_fsel[1] <= freq_sel1;
			m_fsel[2] <= freq_sel2;
			exp0[0] <= gen_model(car_sh[0][m_fsel[0]], env_sh[0][m_addr], amp);
			exp1[0] <= wrap_sum(gen_model(car_sh[1][m_fsel[1]], env_sh[1][m_addr], amp),
				gen_model(car_sh[2][m_fsel[2]], env_sh[2][m_addr], amp));
			for (int k = 1; k < PIPE; k++) begin
				exp0[k] <= exp0[k-1];
				exp1[k] <= exp1[k-1];
			end
			exp_vld <= {exp_vld[PIPE-2:0], model_en};
			if (cap_clear) begin
				m_wcnt <= '0;
				m_full <= 1'b0;
			end else if (!m_full) begin
				if (m_wcnt == '1) begin
					m_full <= 1'b1;
				end else begin
					m_wcnt <= m_wcnt + 1'b1;
				end
			end
			rd_chk_q <= rd_chk;
			rd_acq_q <= rd_acq;
			rd_mon_q <= rd_mon;
		end
	end

	always @(posedge dspif) begin
		cyc <= cyc + 1;
	end

	always @(negedge dspif) begin
		if (cyc < MAX_CYCLES) begin
			adc_log[cyc] <= adc;
			dac1_log[cyc] <= dac1;
		end
	end

	assert property (@(posedge dspif) disable iff (!rst_n) exp_vld[PIPE-1] |-> dac0 == exp0[PIPE-1])
		else show_mismatch("dac0", $sampled(exp0[PIPE-1]), $sampled(dac0));
	assert property (@(posedge dspif) disable iff (!rst_n) exp_vld[PIPE-1] |-> dac1 == exp1[PIPE-1])
		else show_mismatch("dac1", $sampled(exp1[PIPE-1]), $sampled(dac1));
	assert property (@(posedge dspif) disable iff (!rst_n) acq_full == m_full)
		else show_mismatch("acq_full", 64'($sampled(m_full)), 64'($sampled(acq_full)));
	assert property (@(posedge dspif) disable iff (!rst_n) mon_full == m_full)
		else show_mismatch("mon_full", 64'($sampled(m_full)), 64'($sampled(mon_full)));
	assert property (@(posedge dspif) disable iff (!rst_n) rd_chk_q |-> acq_rd_data == rd_acq_q)
		else show_mismatch("acq_readback", $sampled(rd_acq_q), $sampled(acq_rd_data));
	assert property (@(posedge dspif) disable iff (!rst_n) rd_chk_q |-> mon_rd_data == rd_mon_q)
		else show_mismatch("mon_readback", $sampled(rd_mon_q), $sampled(mon_rd_data));

	task automatic next_cycle();
		@(posedge dspif);
		#1;
		adc = {$urandom, $urandom};
	endtask

	task automatic load_tables();
		plps_pkg::table_word_t w;
		for (int t = 0; t < 2 * plps_pkg::N_GEN; t++) begin
			for (int a = 0; a < ((t < plps_pkg::N_GEN) ? 16 : 64); a++) begin
				for (int i = 0; i < plps_pkg::LANES; i++) begin
					w[i*32 +: 32] = $urandom;
				end
				// full-scale entries on drives 1 and 2 push the dac1 sum past 16 bits
				if ((t == 1 || t == 2) && a == 15 || (t == 4 || t == 5) && a >= 60) begin
					w = {plps_pkg::LANES{32'h0000_7fff}};
				end
				if (t < plps_pkg::N_GEN) begin
					car_sh[t][a] = w;
				end else begin
					env_sh[t-plps_pkg::N_GEN][a] = w;
				end
				tbl_we = 1'b1;
				tbl_sel = plps_pkg::TBL_SEL_W'(t);
				tbl_addr = plps_pkg::ENV_AW'(a);
				tbl_wdata = w;
				next_cycle();
			end
		end
		tbl_we = 1'b0;
	endtask

	// acq entry k from adc at clear + k, mon entry k from dac1 at clear + k + 1
	task automatic read_back(input int clr);
		for (int k = 0; k < 2**plps_pkg::CAP_AW; k++) begin
			rd_addr = plps_pkg::CAP_AW'(k);
			rd_chk = 1'b1;
			rd_acq = adc_log[clr+k];
			rd_mon = dac1_log[clr+k+1];
			next_cycle();
		end
		rd_chk = 1'b0;
	endtask

	initial begin
		while (cyc < MAX_CYCLES) begin
			@(posedge dspif);
		end
		$display("timeout: run still going after %0d cycles", MAX_CYCLES);
		$display("errors: tb %0d, checker %0d", n_errors,
			dsp_top_inst.dsp_checker_inst.fail_count);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		int clr;
		int total;
		void'($urandom(41243));
		rst_n = 1'b0;
		run = 1'b0;
		amp = '0;
		freq_sel0 = '0;
		freq_sel1 = '0;
		freq_sel2 = '0;
		tbl_we = 1'b0;
		tbl_sel = '0;
		tbl_addr = '0;
		tbl_wdata = '0;
		adc = '0;
		cap_clear = 1'b0;
		rd_addr = '0;
		model_en = 1'b0;
		rd_chk = 1'b0;
		rd_acq = '0;
		rd_mon = '0;
		repeat (4) @(posedge dspif);
		#1;
		rst_n = 1'b1;
		phase = "load";
		load_tables();
		amp = 16'h6000 | 16'($urandom_range(0, 4095));
		freq_sel0 = 4'($urandom_range(0, 15));
		freq_sel1 = 4'($urandom_range(0, 14));
		freq_sel2 = 4'hf;
		next_cycle();
		next_cycle();
		model_en = 1'b1;
		phase = "run";
		run = 1'b1;
		cap_clear = 1'b1;
		clr = cyc;
		next_cycle();
		cap_clear = 1'b0;
		for (int i = 0; i < 128; i++) begin
			if (i == 70) begin
				freq_sel1 = 4'hf;
			end
			next_cycle();
		end
		run = 1'b0;
		repeat (PIPE + 2) next_cycle();
		phase = "readback1";
		read_back(clr);
		phase = "capture2";
		run = 1'b1;
		cap_clear = 1'b1;
		clr = cyc;
		next_cycle();
		cap_clear = 1'b0;
		while (!acq_full) begin
			next_cycle();
		end
		run = 1'b0;
		repeat (4) next_cycle();
		phase = "readback2";
		read_back(clr);
		repeat (4) next_cycle();
		total = n_errors + dsp_top_inst.dsp_checker_inst.fail_count;
		$display("errors: tb %0d, checker %0d", n_errors,
			dsp_top_inst.dsp_checker_inst.fail_count);
		if (total == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
src/plps_pkg.sv
src/wave_mem.sv
src/env_sequencer.sv
src/ammod.sv
src/dac_mix.sv
src/capture_buf.sv
src/dsp_top.sv
verification/tb_clock.sv
verification/dsp_checker.sv
verification/tb_dsp.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_dsp
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal
SIM_ARGS ?= +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; true
	cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
